/* logic/blue_bus_pkg.sv */
// Datapath types shared by every unit on the internal transfer bus
// Word, address and select widths, the fixed select codes and the
// ALU operation set applied to the accumulator
`default_nettype none

package blue_bus_pkg;

   // Bus and register word
   typedef logic [15:0] word_t;
   // Instruction address, 256 words of program space
   typedef logic [7:0] addr_t;
   // Unit select code on the transfer bus
   typedef logic [3:0] sel_t;

   //////////////////////////////////////////////////////////////////////
   // Select codes
   //////////////////////////////////////////////////////////////////////
   // Codes 0 and 1 have no unit and read as zero
   localparam sel_t SEL_OUT = 4'd2;
   localparam sel_t SEL_P = 4'd3;
   localparam sel_t SEL_A = 4'd4;
   // General registers fill SEL_R0 up to 15
   localparam sel_t SEL_R0 = 4'd5;

   // Operation applied to A and the bus word when A is written
   typedef enum logic [2:0] {
      ALU_PASS = 3'd0,
      ALU_ADD = 3'd1,
      ALU_SUB = 3'd2,
      ALU_AND = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_t;

endpackage

`default_nettype wire

/* logic/blue_isa_pkg.sv */
// Instruction set of the accumulator core
// Instruction word layout, opcode encoding, field helpers and the
// states of the one-instruction-at-a-time sequencer
`default_nettype none

package blue_isa_pkg;
   import blue_bus_pkg::*;

   // 15:12 opcode, 11:8 dest, 7:4 source, 7:0 immediate or target
   typedef logic [15:0] instr_t;
   typedef logic [7:0] imm_t;

   // Unlisted codes 10..15 behave as NOP
   typedef enum logic [3:0] {
      OP_NOP = 4'd0,
      OP_MOV = 4'd1,
      OP_LDI = 4'd2,
      OP_ADD = 4'd3,
      OP_SUB = 4'd4,
      OP_AND = 4'd5,
      OP_XOR = 4'd6,
      OP_JMP = 4'd7,
      OP_JZ = 4'd8,
      OP_HALT = 4'd9
   } opcode_t;

   typedef enum logic [2:0] {FETCH, DECODE, SEND, WRITE, HALTED} seq_state_t;

   //////////////////////////////////////////////////////////////////////
   // Field extraction
   //////////////////////////////////////////////////////////////////////
   function automatic opcode_t op_of(instr_t i);
      return opcode_t'(i[15:12]);
   endfunction

   function automatic sel_t dst_of(instr_t i);
      return i[11:8];
   endfunction

   function automatic sel_t src_of(instr_t i);
      return i[7:4];
   endfunction

   function automatic imm_t imm_of(instr_t i);
      return i[7:0];
   endfunction

endpackage

`default_nettype wire

/* logic/xfer_if.sv */
// Internal transfer bus between the sequencer and the datapath units
// The sequencer uses the ctrl side, each unit the unit side and
// drives only its own data field
`timescale 1ns/1ns
`default_nettype none

interface xfer_if
   import blue_bus_pkg::*;
();

   // Write and send selects with their strobes
   sel_t wsel;
   sel_t ssel;
   logic write;
   logic send;
   // Word being written this cycle
   word_t bus;
   alu_op_t alu_op;
   logic pc_inc;

   // Per-unit send fields, zero unless that unit was the sender
   word_t gpr_data;
   word_t acc_data;
   // Live P, also used as fetch address
   word_t pc_data;
   logic zero;

   modport ctrl (
      output wsel, ssel, write, send, bus, alu_op, pc_inc,
      input gpr_data, acc_data, pc_data, zero
   );

   modport unit (
      input wsel, ssel, write, send, bus, alu_op, pc_inc,
      output gpr_data, acc_data, pc_data, zero
   );

endinterface

`default_nettype wire

/* logic/gpreg_file.sv */
// General register file R0..R10 on the transfer bus
// One register is written per write strobe, one is sent per send
// strobe, and the send field goes back to zero otherwise
`timescale 1ns/1ns
`default_nettype none

module gpreg_file
   import blue_bus_pkg::*;
(
   input logic clk,
   input logic rst,
   xfer_if.unit xfer
);

   localparam int NUM_REGS = 11;

   word_t regs [NUM_REGS];
   sel_t w_idx;
   sel_t s_idx;
   logic w_hit;
   logic s_hit;

   // Every code from SEL_R0 upward is a register
   assign w_hit = xfer.write && (xfer.wsel >= SEL_R0);
   assign s_hit = xfer.send && (xfer.ssel >= SEL_R0);
   // Select code to array index
   assign w_idx = xfer.wsel - SEL_R0;
   assign s_idx = xfer.ssel - SEL_R0;

   //////////////////////////////////////////////////////////////////////
   // Register storage
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (w_hit) begin
         regs[w_idx] <= xfer.bus;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Send field
   //////////////////////////////////////////////////////////////////////
   // Zero when not selected so the sequencer can OR all fields
   always_ff @(posedge clk) begin
      if (rst) begin
         xfer.gpr_data <= '0;
      end else if (s_hit) begin
         xfer.gpr_data <= regs[s_idx];
      end else begin
         xfer.gpr_data <= '0;
      end
   end

endmodule

`default_nettype wire

/* logic/acc_unit.sv */
// Accumulator A with its ALU and zero flag
// On a write to SEL_A the ALU combines A with the bus word, all
// arithmetic wrapping at 16 bits
`timescale 1ns/1ns
`default_nettype none

module acc_unit
   import blue_bus_pkg::*;
(
   input logic clk,
   input logic rst,
   xfer_if.unit xfer
);

   word_t a;
   word_t alu_res;

   // ALU on current A and the incoming word
   always_comb begin
      case (xfer.alu_op)
         ALU_ADD: alu_res = a + xfer.bus;
         ALU_SUB: alu_res = a - xfer.bus;
         ALU_AND: alu_res = a & xfer.bus;
         ALU_XOR: alu_res = a ^ xfer.bus;
         // PASS and unused codes load the bus word
         default: alu_res = xfer.bus;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         a <= '0;
      end else if (xfer.write && (xfer.wsel == SEL_A)) begin
         a <= alu_res;
      end
   end

   // Send field, zero unless A is the source
   always_ff @(posedge clk) begin
      if (rst) begin
         xfer.acc_data <= '0;
      end else if (xfer.send && (xfer.ssel == SEL_A)) begin
         xfer.acc_data <= a;
      end else begin
         xfer.acc_data <= '0;
      end
   end

   // Flag for JZ, sampled by the sequencer in DECODE
   assign xfer.zero = (a == '0);

endmodule

`default_nettype wire

/* logic/pc_unit.sv */
// Program counter P
// Steps once per fetch, loads from the bus on a write to SEL_P and
// is always visible on pc_data for fetch and for reads of P
`timescale 1ns/1ns
`default_nettype none

module pc_unit
   import blue_bus_pkg::*;
#(
   parameter addr_t RESET_PC = '0
) (
   input logic clk,
   input logic rst,
   xfer_if.unit xfer
);

   addr_t p;

   // Jumps and the increment never fall in the same cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         p <= RESET_PC;
      end else if (xfer.write && (xfer.wsel == SEL_P)) begin
         // Only the low byte is an address
         p <= xfer.bus[7:0];
      end else if (xfer.pc_inc) begin
         p <= p + 8'd1;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Zero-extended P
   //////////////////////////////////////////////////////////////////////
   // P already stepped on the ack, so a read of P in SEND gives
   // the address after the current instruction
   assign xfer.pc_data = {8'h00, p};

endmodule

`default_nettype wire

/* logic/sequencer.sv */
// Instruction sequencer of the accumulator core
// Fetches over a read-only Wishbone classic master port, decodes,
// then runs one send cycle and one write cycle on the transfer bus.
// Also holds the output port, written through select code SEL_OUT
`timescale 1ns/1ns
`default_nettype none

module sequencer
   import blue_bus_pkg::*;
   import blue_isa_pkg::*;
(
   input logic clk,
   input logic rst,
   output addr_t wb_adr,
   input instr_t wb_dat_r,
   output logic wb_cyc,
   output logic wb_stb,
   input logic wb_ack,
   output word_t out_data,
   output logic out_valid,
   output logic halted,
   xfer_if.ctrl xfer
);

   seq_state_t state;
   logic cyc_q;
   instr_t instr_q;

   // Decoded controls, combinational
   sel_t d_wsel;
   sel_t d_ssel;
   alu_op_t d_alu;
   logic d_write;
   logic d_send;
   logic d_imm;

   // Decoded controls, held from DECODE to WRITE
   sel_t wsel_q;
   sel_t ssel_q;
   alu_op_t alu_q;
   logic write_q;
   logic send_q;
   logic imm_q;

   //////////////////////////////////////////////////////////////////////
   // Wishbone fetch
   //////////////////////////////////////////////////////////////////////
   assign wb_cyc = cyc_q;
   assign wb_stb = cyc_q;
   // P does not move while a request is open
   assign wb_adr = xfer.pc_data[7:0];
   // Step P in the ack cycle
   assign xfer.pc_inc = (state == FETCH) && cyc_q && wb_ack;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= FETCH;
         cyc_q <= 1'b0;
      end else begin
         case (state)
            FETCH: begin
               // Request opens one cycle into FETCH, drops after ack
               if (cyc_q && wb_ack) begin
                  cyc_q <= 1'b0;
                  state <= DECODE;
               end else begin
                  cyc_q <= 1'b1;
               end
            end
            DECODE: begin
               state <= (op_of(instr_q) == OP_HALT) ? HALTED : SEND;
            end
            SEND: state <= WRITE;
            WRITE: state <= FETCH;
            // Only reset leaves HALTED
            default: state <= HALTED;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == FETCH) && cyc_q && wb_ack) begin
         instr_q <= wb_dat_r;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      d_wsel = dst_of(instr_q);
      d_ssel = src_of(instr_q);
      d_alu = ALU_PASS;
      d_write = 1'b0;
      d_send = 1'b0;
      d_imm = 1'b0;
      case (op_of(instr_q))
         OP_MOV: begin
            d_write = 1'b1;
            d_send = 1'b1;
         end
         OP_LDI: begin
            d_write = 1'b1;
            d_imm = 1'b1;
         end
         // ALU group always lands in A
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            d_wsel = SEL_A;
            d_write = 1'b1;
            d_send = 1'b1;
            case (op_of(instr_q))
               OP_ADD: d_alu = ALU_ADD;
               OP_SUB: d_alu = ALU_SUB;
               OP_AND: d_alu = ALU_AND;
               default: d_alu = ALU_XOR;
            endcase
         end
         OP_JMP: begin
            d_wsel = SEL_P;
            d_write = 1'b1;
            d_imm = 1'b1;
         end
         // Not taken means no write at all
         OP_JZ: begin
            d_wsel = SEL_P;
            d_write = xfer.zero;
            d_imm = 1'b1;
         end
         default: begin
            d_write = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wsel_q <= '0;
         ssel_q <= '0;
         alu_q <= ALU_PASS;
         write_q <= 1'b0;
         send_q <= 1'b0;
         imm_q <= 1'b0;
      end else if (state == DECODE) begin
         wsel_q <= d_wsel;
         ssel_q <= d_ssel;
         alu_q <= d_alu;
         write_q <= d_write;
         send_q <= d_send;
         imm_q <= d_imm;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Transfer bus
   //////////////////////////////////////////////////////////////////////
   assign xfer.wsel = wsel_q;
   assign xfer.ssel = ssel_q;
   assign xfer.alu_op = alu_q;
   assign xfer.send = (state == SEND) && send_q;
   assign xfer.write = (state == WRITE) && write_q;

   // pc_data is always live, so it only joins the OR when P is the source
   always_comb begin
      if (imm_q) begin
         xfer.bus = {8'h00, imm_of(instr_q)};
      end else if (ssel_q == SEL_P) begin
         xfer.bus = xfer.gpr_data | xfer.acc_data | xfer.pc_data;
      end else begin
         xfer.bus = xfer.gpr_data | xfer.acc_data;
      end
   end

   // Output port, visible the cycle after WRITE
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= xfer.write && (xfer.wsel == SEL_OUT);
      end
   end

   always_ff @(posedge clk) begin
      if (xfer.write && (xfer.wsel == SEL_OUT)) begin
         out_data <= xfer.bus;
      end
   end

   assign halted = (state == HALTED);

endmodule

`default_nettype wire

/* logic/blue_core.sv */
// Top level of the accumulator core
// Wishbone classic read-only port for instruction fetch, one output
// port and a halted flag. RESET_PC sets the first fetch address
`timescale 1ns/1ns
`default_nettype none

module blue_core
   import blue_bus_pkg::*;
   import blue_isa_pkg::*;
#(
   parameter addr_t RESET_PC = '0
) (
   input logic clk,
   input logic rst,
   // Instruction fetch
   output addr_t wb_adr,
   input instr_t wb_dat_r,
   output logic wb_cyc,
   output logic wb_stb,
   input logic wb_ack,
   // Output port and status
   output word_t out_data,
   output logic out_valid,
   output logic halted
);

   // Shared transfer bus
   xfer_if xfer ();

   sequencer u_seq (
      .clk (clk),
      .rst (rst),
      .wb_adr (wb_adr),
      .wb_dat_r (wb_dat_r),
      .wb_cyc (wb_cyc),
      .wb_stb (wb_stb),
      .wb_ack (wb_ack),
      .out_data (out_data),
      .out_valid (out_valid),
      .halted (halted),
      .xfer (xfer.ctrl)
   );

   //////////////////////////////////////////////////////////////////////
   // Datapath units
   //////////////////////////////////////////////////////////////////////
   gpreg_file u_gpr (
      .clk (clk),
      .rst (rst),
      .xfer (xfer.unit)
   );

   acc_unit u_acc (
      .clk (clk),
      .rst (rst),
      .xfer (xfer.unit)
   );

   pc_unit #(
      .RESET_PC (RESET_PC)
   ) u_pc (
      .clk (clk),
      .rst (rst),
      .xfer (xfer.unit)
   );

endmodule

`default_nettype wire

/* bench/wb_rom_model.sv */
// Read-only Wishbone classic memory for the core testbench
// The testbench writes program words straight into mem. Each request
// is acked after 0 to 3 random wait cycles, ack high for one cycle
`timescale 1ns/1ns
`default_nettype none

module wb_rom_model
   import blue_bus_pkg::*;
   import blue_isa_pkg::*;
(
   input logic clk,
   input logic rst,
   input addr_t adr,
   input logic cyc,
   input logic stb,
   output logic ack,
   output instr_t dat
);

   // Program space, filled by the testbench
   instr_t mem [256];

   int wait_left;
   logic busy;

   // Responds just after the clock edge, where cyc, stb and adr are settled
   initial begin
      ack = 1'b0;
      dat = '0;
      busy = 1'b0;
      wait_left = 0;
      forever begin
         @(posedge clk);
         #1;
         if (rst) begin
            ack = 1'b0;
            busy = 1'b0;
         end else if (ack) begin
            // Master saw the ack and drops the request now
            ack = 1'b0;
         end else if (cyc && stb) begin
            // New request picks its delay once
            if (!busy) begin
               busy = 1'b1;
               wait_left = $urandom % 4;
            end
            if (wait_left == 0) begin
               ack = 1'b1;
               dat = mem[adr];
               busy = 1'b0;
            end else begin
               wait_left--;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* bench/blue_core_tb.sv */
// Testbench for the accumulator core
// Runs a table of small programs from the Wishbone memory model and
// compares the words seen on the output port with expected lists
`timescale 1ns/1ns
`default_nettype none

module blue_core_tb
   import blue_bus_pkg::*;
   import blue_isa_pkg::*;
();

   localparam int NUM_TESTS = 5;
   localparam int MAX_PROG = 24;
   localparam int MAX_OUT = 16;
   // Cycle budget for one program to reach halted
   localparam int RUN_LIMIT = 1000;
   // Window after halted in which the output port must stay quiet
   localparam int QUIET_CYCLES = 40;

   localparam instr_t HALT_I = {OP_HALT, 12'h000};
   // Opcode 12 is unassigned
   localparam instr_t NOP_I = 16'hC000;

   logic clk;
   logic rst;
   addr_t wb_adr;
   instr_t wb_dat_r;
   logic wb_cyc;
   logic wb_stb;
   logic wb_ack;
   word_t out_data;
   logic out_valid;
   logic halted;

   // Test table, programs and expected output words
   string name_tab [NUM_TESTS];
   instr_t prog_tab [NUM_TESTS][MAX_PROG];
   int prog_len [NUM_TESTS];
   word_t exp_tab [NUM_TESTS][MAX_OUT];
   int exp_len [NUM_TESTS];

   int error_count;
   int tests_ok;
   int unsigned seed_ret;

   blue_core #(
      .RESET_PC (8'h00)
   ) dut0 (
      .clk (clk),
      .rst (rst),
      .wb_adr (wb_adr),
      .wb_dat_r (wb_dat_r),
      .wb_cyc (wb_cyc),
      .wb_stb (wb_stb),
      .wb_ack (wb_ack),
      .out_data (out_data),
      .out_valid (out_valid),
      .halted (halted)
   );

   wb_rom_model rom0 (
      .clk (clk),
      .rst (rst),
      .adr (wb_adr),
      .cyc (wb_cyc),
      .stb (wb_stb),
      .ack (wb_ack),
      .dat (wb_dat_r)
   );

   // 40 ns period
   always #20 clk = ~clk;

   ///////////////////////////////////////////////////////////////////////
   // Instruction encoding
   ///////////////////////////////////////////////////////////////////////
   function automatic instr_t ldi(sel_t dst, imm_t imm);
      return {OP_LDI, dst, imm};
   endfunction

   function automatic instr_t mov(sel_t dst, sel_t src);
      return {OP_MOV, dst, src, 4'h0};
   endfunction

   // ALU group, destination field unused
   function automatic instr_t alu(opcode_t op, sel_t src);
      return {op, 4'h0, src, 4'h0};
   endfunction

   // JMP or JZ to an absolute address
   function automatic instr_t jump(opcode_t op, imm_t target);
      return {op, 4'h0, target};
   endfunction

   task automatic add_instr(int t, instr_t i);
      prog_tab[t][prog_len[t]] = i;
      prog_len[t]++;
   endtask

   task automatic add_exp(int t, word_t w);
      exp_tab[t][exp_len[t]] = w;
      exp_len[t]++;
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Test table
   ///////////////////////////////////////////////////////////////////////
   task automatic build_tests();
      word_t acc;
      word_t r0;
      imm_t imm;
      for (int t = 0; t < NUM_TESTS; t++) begin
         prog_len[t] = 0;
         exp_len[t] = 0;
      end
      // Load all eleven registers first, then read each back
      name_tab[0] = "regs";
      for (int k = 0; k < 11; k++) begin
         add_instr(0, ldi(sel_t'(SEL_R0 + k), imm_t'(k * 23 + 5)));
      end
      for (int k = 0; k < 11; k++) begin
         imm = imm_t'(k * 23 + 5);
         add_instr(0, mov(SEL_OUT, sel_t'(SEL_R0 + k)));
         add_exp(0, {8'h00, imm});
      end
      add_instr(0, HALT_I);
      // A = 0x20 and R0 = 0xF0, second SUB wraps below zero
      name_tab[1] = "alu";
      acc = 16'h0020;
      r0 = 16'h00F0;
      add_instr(1, ldi(SEL_A, acc[7:0]));
      add_instr(1, ldi(SEL_R0, r0[7:0]));
      acc = acc + r0;
      add_instr(1, alu(OP_ADD, SEL_R0));
      add_instr(1, mov(SEL_OUT, SEL_A));
      add_exp(1, acc);
      for (int n = 0; n < 2; n++) begin
         acc = acc - r0;
         add_instr(1, alu(OP_SUB, SEL_R0));
         add_instr(1, mov(SEL_OUT, SEL_A));
         add_exp(1, acc);
      end
      acc = acc & r0;
      add_instr(1, alu(OP_AND, SEL_R0));
      add_instr(1, mov(SEL_OUT, SEL_A));
      add_exp(1, acc);
      acc = acc ^ r0;
      add_instr(1, alu(OP_XOR, SEL_R0));
      add_instr(1, mov(SEL_OUT, SEL_A));
      add_exp(1, acc);
      add_instr(1, HALT_I);
      // 0xEE words sit on skipped paths
      name_tab[2] = "jumps";
      add_instr(2, jump(OP_JMP, 8'd2));
      add_instr(2, ldi(SEL_OUT, 8'hEE));
      add_instr(2, ldi(SEL_OUT, 8'h01));
      add_instr(2, ldi(SEL_A, 8'h00));
      // Taken, A is zero
      add_instr(2, jump(OP_JZ, 8'd6));
      add_instr(2, ldi(SEL_OUT, 8'hEE));
      add_instr(2, ldi(SEL_OUT, 8'h02));
      add_instr(2, ldi(SEL_A, 8'h07));
      // Not taken, falls through to address 9
      add_instr(2, jump(OP_JZ, 8'd10));
      add_instr(2, ldi(SEL_OUT, 8'h03));
      add_instr(2, ldi(SEL_OUT, 8'h04));
      add_instr(2, HALT_I);
      add_exp(2, 16'h0001);
      add_exp(2, 16'h0002);
      add_exp(2, 16'h0003);
      add_exp(2, 16'h0004);
      // Reads of P give the next address, codes 0 and 1 give zero
      name_tab[3] = "pc_read";
      add_instr(3, ldi(SEL_A, 8'h55));
      add_instr(3, ldi(SEL_R0, 8'h66));
      add_exp(3, word_t'(prog_len[3] + 1));
      add_instr(3, mov(SEL_OUT, SEL_P));
      add_instr(3, NOP_I);
      add_exp(3, word_t'(prog_len[3] + 1));
      add_instr(3, mov(SEL_OUT, SEL_P));
      add_instr(3, mov(SEL_OUT, 4'd0));
      add_exp(3, 16'h0000);
      add_instr(3, mov(SEL_OUT, 4'd1));
      add_exp(3, 16'h0000);
      add_instr(3, HALT_I);
      // Words after HALT must never reach the port
      name_tab[4] = "halt";
      add_instr(4, ldi(SEL_OUT, 8'h5A));
      add_exp(4, 16'h005A);
      add_instr(4, HALT_I);
      add_instr(4, ldi(SEL_OUT, 8'hA5));
      add_instr(4, ldi(SEL_OUT, 8'hA6));
   endtask

   ///////////////////////////////////////////////////////////////////////
   // Checking and running
   ///////////////////////////////////////////////////////////////////////
   task automatic check_value(string what, int got, int exp, bit as_word);
      if (got != exp) begin
         error_count++;
         if (as_word) begin
            $display("[ERROR] %s: got 0x%04h, expected 0x%04h", what, got[15:0], exp[15:0]);
         end else begin
            $display("%s is %0d but %0d was expected", what, got, exp);
         end
      end
   endtask

   task automatic run_test(int t);
      word_t got [$];
      int cycles;
      int errs_before;
      seq_state_t st;
      addr_t adr_prev;
      logic cyc_prev;
      errs_before = error_count;
      @(posedge clk);
      #1;
      rst = 1'b1;
      // Unused words are HALT with the address in the low byte
      for (int a = 0; a < 256; a++) begin
         rom0.mem[a] = {OP_HALT, 4'h0, 8'(a)};
      end
      for (int i = 0; i < prog_len[t]; i++) begin
         rom0.mem[i] = prog_tab[t][i];
      end
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      // No request open straight out of reset
      check_value($sformatf("%s wb_cyc", name_tab[t]), int'(wb_cyc), 0, 1'b1);
      check_value($sformatf("%s wb_stb", name_tab[t]), int'(wb_stb), 0, 1'b1);
      cyc_prev = 1'b0;
      adr_prev = '0;
      // Collect port words until halted
      cycles = 0;
      while (!halted && cycles < RUN_LIMIT) begin
         @(posedge clk);
         #1;
         if (out_valid) begin
            got.push_back(out_data);
         end
         // Strobe rises and falls with cycle
         check_value($sformatf("%s wb_stb", name_tab[t]), int'(wb_stb),
                     int'(wb_cyc), 1'b1);
         // Address held for the whole request
         if (cyc_prev && wb_cyc) begin
            check_value($sformatf("%s wb_adr", name_tab[t]), int'(wb_adr),
                        int'(adr_prev), 1'b1);
         end
         cyc_prev = wb_cyc;
         adr_prev = wb_adr;
         cycles++;
      end
      if (!halted) begin
         st = dut0.u_seq.state;
         $display("Test %s did not halt within %0d cycles, sequencer in state %s",
                  name_tab[t], RUN_LIMIT, st.name());
         error_count++;
      end else begin
         for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(posedge clk);
            #1;
            if (out_valid) begin
               $display("Test %s wrote 0x%04h to the output port after halting",
                        name_tab[t], out_data);
               error_count++;
            end
            // Halted core fetches nothing more
            check_value($sformatf("%s wb_cyc after halt", name_tab[t]), int'(wb_cyc),
                        0, 1'b1);
         end
         check_value($sformatf("%s halted", name_tab[t]), int'(halted), 1, 1'b1);
      end
      check_value($sformatf("Output word count of %s", name_tab[t]), got.size(),
                  exp_len[t], 1'b0);
      for (int i = 0; i < exp_len[t] && i < got.size(); i++) begin
         check_value($sformatf("%s out_data word %0d", name_tab[t], i), int'(got[i]),
                     int'(exp_tab[t][i]), 1'b1);
      end
      if (error_count == errs_before) begin
         tests_ok++;
         $display("Test %s ok, %0d words in %0d cycles", name_tab[t], got.size(), cycles);
      end else begin
         $display("Test %s FAILED with %0d errors", name_tab[t], error_count - errs_before);
      end
   endtask

   initial begin
      seed_ret = $urandom(99687);
      clk = 1'b0;
      rst = 1'b1;
      error_count = 0;
      tests_ok = 0;
      build_tests();
      for (int t = 0; t < NUM_TESTS; t++) begin
         run_test(t);
      end
      $display("%0d of %0d tests ok, %0d errors", tests_ok, NUM_TESTS, error_count);
      if (error_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
logic/blue_bus_pkg.sv
logic/blue_isa_pkg.sv
logic/xfer_if.sv
logic/gpreg_file.sv
logic/acc_unit.sv
logic/pc_unit.sv
logic/sequencer.sv
logic/blue_core.sv
bench/wb_rom_model.sv
bench/blue_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it
# Exit status is nonzero unless the run reports a pass
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module blue_core_tb \
   -f verilog.f -o blue_core_sim \
   && ./obj_dir/blue_core_sim | tee /dev/stderr | grep -qx "test passed" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
